//--- hdl/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // execute-stage opcodes, as handed over by decode
    typedef enum logic [7:0] {
        ALUOP_NOP    = 8'h00,
        ALUOP_ADD    = 8'h01,
        ALUOP_ADDI   = 8'h02,
        ALUOP_ADDU   = 8'h03,
        ALUOP_ADDIU  = 8'h04,
        ALUOP_SUB    = 8'h05,
        ALUOP_SUBU   = 8'h06,
        ALUOP_SLT    = 8'h07,
        ALUOP_SLTI   = 8'h08,
        ALUOP_SLTU   = 8'h09,
        ALUOP_SLTIU  = 8'h0a,
        ALUOP_MULT   = 8'h0d,
        ALUOP_MULTU  = 8'h0e,
        ALUOP_AND    = 8'h10,
        ALUOP_ANDI   = 8'h11,
        ALUOP_LUI    = 8'h12,
        ALUOP_NOR    = 8'h13,
        ALUOP_OR     = 8'h14,
        ALUOP_ORI    = 8'h15,
        ALUOP_XOR    = 8'h16,
        ALUOP_XORI   = 8'h17,
        ALUOP_SLL    = 8'h18,
        ALUOP_SLLV   = 8'h19,
        ALUOP_SRA    = 8'h1a,
        ALUOP_SRAV   = 8'h1b,
        ALUOP_SRL    = 8'h1c,
        ALUOP_SRLV   = 8'h1d,
        ALUOP_BGEZAL = 8'h20,
        ALUOP_BLTZAL = 8'h21,
        ALUOP_JAL    = 8'h23,
        ALUOP_JALR   = 8'h25,
        ALUOP_MFHI   = 8'h28,
        ALUOP_MFLO   = 8'h29,
        ALUOP_MTHI   = 8'h2a,
        ALUOP_MTLO   = 8'h2b,
        ALUOP_LB     = 8'h30,
        ALUOP_LBU    = 8'h31,
        ALUOP_LH     = 8'h32,
        ALUOP_LHU    = 8'h33,
        ALUOP_LW     = 8'h34,
        ALUOP_SB     = 8'h35,
        ALUOP_SH     = 8'h36,
        ALUOP_SW     = 8'h37
    } aluop_e;

    // instruction word fields
    localparam int SHAMT_LSB    = 6;
    localparam int SHAMT_MSB    = 10;
    localparam int RD_FIELD_LSB = 11;
    localparam int IMM_MSB      = 15;

endpackage

`default_nettype wire

//--- hdl/exe_types_pkg.sv
`default_nettype none

package exe_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  gpr_addr_t;

    // $ra, written by the link instructions
    localparam gpr_addr_t LINK_REG = 5'd31;

    // $zero, writes here are discarded
    localparam gpr_addr_t ZERO_REG = 5'd0;

endpackage

`default_nettype wire

//--- hdl/exe_result_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exe_result_if
    import exe_types_pkg::*;
#(
    parameter int XLEN = 32
) ();

    logic            valid;
    logic            gpr_we;
    gpr_addr_t       gpr_addr;
    logic [XLEN-1:0] gpr_data;
    logic            overflow;
    logic            hi_we;
    logic            lo_we;
    logic [XLEN-1:0] hi_data;
    logic [XLEN-1:0] lo_data;

    modport src (
        output valid, gpr_we, gpr_addr, gpr_data, overflow,
        output hi_we, lo_we, hi_data, lo_data
    );

    modport dst (
        input valid, gpr_we, gpr_addr, gpr_data, overflow,
        input hi_we, lo_we, hi_data, lo_data
    );

endinterface

`default_nettype wire

//--- hdl/exe_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exe_alu
    import mips_isa_pkg::*;
    import exe_types_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic      issue_i,
    input  aluop_e    aluop_i,
    input  word_t     rs_data_i,
    input  word_t     rt_data_i,
    input  word_t     instr_i,
    input  word_t     link_addr_i,
    input  gpr_addr_t dest_addr_i,
    input  logic      reg_write_i,
    input  word_t     hi_fwd_i,
    input  word_t     lo_fwd_i,
    exe_result_if.src res_o
);

    localparam int SHW = $clog2(XLEN);

    word_t          sign_imm;
    word_t          zero_imm;
    word_t          upper_imm;
    logic [SHW-1:0] shamt_imm;
    logic [SHW-1:0] shamt_reg;
    word_t          sum_rr;
    word_t          sum_ri;
    word_t          diff;
    word_t          alu_data;
    dword_t         hilo_wdata;
    logic           hi_we;
    logic           lo_we;
    logic           ovf;
    gpr_addr_t      dest;

    // signed overflow of a + b = s
    function automatic logic add_ovf(input word_t a, input word_t b, input word_t s);
        return (a[XLEN-1] == b[XLEN-1]) && (s[XLEN-1] != a[XLEN-1]);
    endfunction

    // immediates built from the instruction word
    assign sign_imm  = {{(XLEN-IMM_MSB-1){instr_i[IMM_MSB]}}, instr_i[IMM_MSB:0]};
    assign zero_imm  = {{(XLEN-IMM_MSB-1){1'b0}}, instr_i[IMM_MSB:0]};
    assign upper_imm = {instr_i[IMM_MSB:0], {(XLEN-IMM_MSB-1){1'b0}}};
    assign shamt_imm = instr_i[SHAMT_MSB:SHAMT_LSB];
    assign shamt_reg = rs_data_i[SHW-1:0];

    assign sum_rr = rs_data_i + rt_data_i;
    assign sum_ri = rs_data_i + sign_imm;
    assign diff   = rs_data_i - rt_data_i;

    always_comb begin
        alu_data   = '0;
        hilo_wdata = '0;
        hi_we      = 1'b0;
        lo_we      = 1'b0;
        ovf        = 1'b0;
        case (aluop_i)
            ALUOP_ADD: begin
                alu_data = sum_rr;
                ovf      = add_ovf(rs_data_i, rt_data_i, sum_rr);
            end
            ALUOP_ADDI: begin
                alu_data = sum_ri;
                ovf      = add_ovf(rs_data_i, sign_imm, sum_ri);
            end
            ALUOP_SUB: begin
                alu_data = diff;
                // rs - rt is rs + ~rt + 1
                ovf      = add_ovf(rs_data_i, ~rt_data_i, diff);
            end
            ALUOP_ADDU:  alu_data = sum_rr;
            ALUOP_ADDIU: alu_data = sum_ri;
            ALUOP_SUBU:  alu_data = diff;
            ALUOP_SLT:   alu_data = word_t'($signed(rs_data_i) < $signed(rt_data_i));
            ALUOP_SLTI:  alu_data = word_t'($signed(rs_data_i) < $signed(sign_imm));
            ALUOP_SLTU:  alu_data = word_t'(rs_data_i < rt_data_i);
            ALUOP_SLTIU: alu_data = word_t'(rs_data_i < sign_imm);
            ALUOP_AND:   alu_data = rs_data_i & rt_data_i;
            ALUOP_ANDI:  alu_data = rs_data_i & zero_imm;
            ALUOP_LUI:   alu_data = upper_imm;
            ALUOP_NOR:   alu_data = ~(rs_data_i | rt_data_i);
            ALUOP_OR:    alu_data = rs_data_i | rt_data_i;
            ALUOP_ORI:   alu_data = rs_data_i | zero_imm;
            ALUOP_XOR:   alu_data = rs_data_i ^ rt_data_i;
            ALUOP_XORI:  alu_data = rs_data_i ^ zero_imm;
            ALUOP_SLL:   alu_data = rt_data_i << shamt_imm;
            ALUOP_SLLV:  alu_data = rt_data_i << shamt_reg;
            ALUOP_SRA:   alu_data = $signed(rt_data_i) >>> shamt_imm;
            ALUOP_SRAV:  alu_data = $signed(rt_data_i) >>> shamt_reg;
            ALUOP_SRL:   alu_data = rt_data_i >> shamt_imm;
            ALUOP_SRLV:  alu_data = rt_data_i >> shamt_reg;
            ALUOP_JAL, ALUOP_JALR, ALUOP_BGEZAL, ALUOP_BLTZAL: begin
                alu_data = link_addr_i;
            end
            ALUOP_MFHI: alu_data = hi_fwd_i;
            ALUOP_MFLO: alu_data = lo_fwd_i;
            ALUOP_MTHI: begin
                hilo_wdata = {rs_data_i, rs_data_i};
                hi_we      = 1'b1;
            end
            ALUOP_MTLO: begin
                hilo_wdata = {rs_data_i, rs_data_i};
                lo_we      = 1'b1;
            end
            ALUOP_MULT: begin
                hilo_wdata = $signed(rs_data_i) * $signed(rt_data_i);
                hi_we      = 1'b1;
                lo_we      = 1'b1;
            end
            ALUOP_MULTU: begin
                hilo_wdata = rs_data_i * rt_data_i;
                hi_we      = 1'b1;
                lo_we      = 1'b1;
            end
            // effective address for loads and stores
            ALUOP_LB, ALUOP_LBU, ALUOP_LH, ALUOP_LHU, ALUOP_LW,
            ALUOP_SB, ALUOP_SH, ALUOP_SW: begin
                alu_data = sum_ri;
            end
            default: alu_data = '0;
        endcase
    end

    // overflowing results go to $zero
    always_comb begin
        dest = dest_addr_i;
        if (ovf) begin
            dest = ZERO_REG;
        end else if (aluop_i inside {ALUOP_JAL, ALUOP_BGEZAL, ALUOP_BLTZAL}) begin
            dest = LINK_REG;
        end else if (aluop_i == ALUOP_JALR) begin
            // jalr names its link register in rd
            dest = instr_i[RD_FIELD_LSB +: $bits(gpr_addr_t)];
        end
    end

    assign res_o.valid    = issue_i;
    assign res_o.gpr_we   = reg_write_i;
    assign res_o.gpr_addr = dest;
    assign res_o.gpr_data = alu_data;
    assign res_o.overflow = ovf;
    assign res_o.hi_we    = hi_we;
    assign res_o.lo_we    = lo_we;
    assign res_o.hi_data  = hilo_wdata[2*XLEN-1:XLEN];
    assign res_o.lo_data  = hilo_wdata[XLEN-1:0];

endmodule

`default_nettype wire

//--- hdl/exe_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage_reg
    import exe_types_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic      div_done,
    input  logic      reset_i,
    exe_result_if.dst in_i,
    exe_result_if.src out_o
);

    logic            valid_q;
    logic            gpr_we_q;
    logic            overflow_q;
    logic            hi_we_q;
    logic            lo_we_q;
    gpr_addr_t       gpr_addr_q;
    logic [XLEN-1:0] gpr_data_q;
    logic [XLEN-1:0] hi_data_q;
    logic [XLEN-1:0] lo_data_q;

    always_ff @(posedge div_done) begin
        if (reset_i) begin
            valid_q    <= 1'b0;
            gpr_we_q   <= 1'b0;
            overflow_q <= 1'b0;
            hi_we_q    <= 1'b0;
            lo_we_q    <= 1'b0;
        end else begin
            valid_q    <= in_i.valid;
            gpr_we_q   <= in_i.gpr_we;
            overflow_q <= in_i.overflow;
            hi_we_q    <= in_i.hi_we;
            lo_we_q    <= in_i.lo_we;
        end
    end

    // payload
    always_ff @(posedge div_done) begin
        gpr_addr_q <= in_i.gpr_addr;
        gpr_data_q <= in_i.gpr_data;
        hi_data_q  <= in_i.hi_data;
        lo_data_q  <= in_i.lo_data;
    end

    assign out_o.valid    = valid_q;
    assign out_o.gpr_we   = gpr_we_q;
    assign out_o.gpr_addr = gpr_addr_q;
    assign out_o.gpr_data = gpr_data_q;
    assign out_o.overflow = overflow_q;
    assign out_o.hi_we    = hi_we_q;
    assign out_o.lo_we    = lo_we_q;
    assign out_o.hi_data  = hi_data_q;
    assign out_o.lo_data  = lo_data_q;

endmodule

`default_nettype wire

//--- hdl/hilo_regs.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_regs
    import exe_types_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic      div_done,
    input  logic      reset_i,
    exe_result_if.dst wr_i,
    output word_t     hi_o,
    output word_t     lo_o,
    output word_t     hi_fwd_o,
    output word_t     lo_fwd_o
);

    logic [XLEN-1:0] hi_q;
    logic [XLEN-1:0] lo_q;
    logic            hi_wr;
    logic            lo_wr;

    assign hi_wr = wr_i.valid && wr_i.hi_we;
    assign lo_wr = wr_i.valid && wr_i.lo_we;

    always_ff @(posedge div_done) begin
        if (reset_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (hi_wr) begin
                hi_q <= wr_i.hi_data;
            end
            if (lo_wr) begin
                lo_q <= wr_i.lo_data;
            end
        end
    end

    assign hi_o = hi_q;
    assign lo_o = lo_q;

    // pending write in the buffer wins over the stored value
    assign hi_fwd_o = hi_wr ? wr_i.hi_data : hi_q;
    assign lo_fwd_o = lo_wr ? wr_i.lo_data : lo_q;

endmodule

`default_nettype wire

//--- hdl/exe_top.sv
`timescale 1ns/1ps
`default_nettype none

module exe_top
    import mips_isa_pkg::*;
    import exe_types_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic      div_done,
    input  logic      reset_i,
    input  logic      issue_i,
    input  aluop_e    aluop_i,
    input  word_t     rs_data_i,
    input  word_t     rt_data_i,
    input  word_t     instr_i,
    input  word_t     link_addr_i,
    input  gpr_addr_t dest_addr_i,
    input  logic      reg_write_i,
    output logic      result_valid_o,
    output logic      result_we_o,
    output gpr_addr_t result_addr_o,
    output word_t     result_data_o,
    output logic      overflow_o,
    output word_t     hi_o,
    output word_t     lo_o
);

    word_t hi_fwd;
    word_t lo_fwd;

    exe_result_if #(.XLEN(XLEN)) alu_res ();
    exe_result_if #(.XLEN(XLEN)) mem_res ();

    exe_alu #(
        .XLEN(XLEN)
    ) u_alu (
        .issue_i    (issue_i),
        .aluop_i    (aluop_i),
        .rs_data_i  (rs_data_i),
        .rt_data_i  (rt_data_i),
        .instr_i    (instr_i),
        .link_addr_i(link_addr_i),
        .dest_addr_i(dest_addr_i),
        .reg_write_i(reg_write_i),
        .hi_fwd_i   (hi_fwd),
        .lo_fwd_i   (lo_fwd),
        .res_o      (alu_res.src)
    );

    exe_stage_reg #(
        .XLEN(XLEN)
    ) u_stage (
        .div_done(div_done),
        .reset_i (reset_i),
        .in_i    (alu_res.dst),
        .out_o   (mem_res.src)
    );

    hilo_regs #(
        .XLEN(XLEN)
    ) u_hilo (
        .div_done(div_done),
        .reset_i (reset_i),
        .wr_i    (mem_res.dst),
        .hi_o    (hi_o),
        .lo_o    (lo_o),
        .hi_fwd_o(hi_fwd),
        .lo_fwd_o(lo_fwd)
    );

    // buffered bundle leaves as the general-purpose result
    assign result_valid_o = mem_res.valid;
    assign result_we_o    = mem_res.gpr_we;
    assign result_addr_o  = mem_res.gpr_addr;
    assign result_data_o  = mem_res.gpr_data;
    assign overflow_o     = mem_res.overflow;

endmodule

`default_nettype wire

//--- test/exe_top_sva.sv
`timescale 1ns/1ps
`default_nettype none

module exe_top_sva
    import exe_types_pkg::*;
(
    input logic      div_done,
    input logic      reset_i,
    input logic      issue_i,
    input logic      valid_i,
    input gpr_addr_t addr_i,
    input logic      ovf_i,
    input word_t     hi_i,
    input logic      buf_valid_i,
    input logic      buf_hi_we_i
);

    int fail_count = 0;

    // one cycle from issue to result
    assert property (@(posedge div_done) disable iff (reset_i)
        !$past(reset_i) |-> valid_i == $past(issue_i))
        else begin
            fail_count++;
            $error("result valid does not follow issue by one cycle");
        end

    assert property (@(posedge div_done) disable iff (reset_i)
        ovf_i |-> addr_i == ZERO_REG)
        else begin
            fail_count++;
            $error("overflow with a destination other than register 0");
        end

    // HI moves only on a committed HI write
    assert property (@(posedge div_done) disable iff (reset_i)
        !$past(reset_i) && $changed(hi_i) |-> $past(buf_valid_i && buf_hi_we_i))
        else begin
            fail_count++;
            $error("HI changed without a valid HI write in the buffer");
        end

endmodule

`default_nettype wire

//--- test/exe_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exe_top_tb
    import mips_isa_pkg::*;
    import exe_types_pkg::*;
();

    localparam int    RESET_CYCLES = 10;
    localparam int    PERIOD_NS    = 4;
    localparam word_t LINK_BASE    = 32'h0040_0100;

    typedef struct {
        string     name;
        aluop_e    op;
        word_t     rs;
        word_t     rt;
        word_t     instr;
        gpr_addr_t dest;
        word_t     exp_data;
        gpr_addr_t exp_addr;
        logic      exp_ovf;
        word_t     exp_hi;
        word_t     exp_lo;
        bit        bad;
    } row_t;

    logic      div_done;
    logic      reset_i;
    logic      issue_i;
    aluop_e    aluop_i;
    word_t     rs_data_i;
    word_t     rt_data_i;
    word_t     instr_i;
    word_t     link_addr_i;
    gpr_addr_t dest_addr_i;
    logic      reg_write_i;
    logic      result_valid_o;
    logic      result_we_o;
    gpr_addr_t result_addr_o;
    word_t     result_data_o;
    logic      overflow_o;
    word_t     hi_o;
    word_t     lo_o;

    row_t   rows[$];
    aluop_e rand_ops[$] = '{ALUOP_ADD, ALUOP_ADDI, ALUOP_SUB, ALUOP_SLT, ALUOP_SLTI,
                            ALUOP_SLTU, ALUOP_SLTIU, ALUOP_AND, ALUOP_ANDI, ALUOP_OR,
                            ALUOP_XOR, ALUOP_XORI, ALUOP_NOR, ALUOP_LUI, ALUOP_SLL,
                            ALUOP_SLLV, ALUOP_SRA, ALUOP_SRAV, ALUOP_SRL, ALUOP_SRLV,
                            ALUOP_LB, ALUOP_SW, ALUOP_JALR, ALUOP_MULT, ALUOP_MFHI,
                            ALUOP_MFLO, ALUOP_MULTU, ALUOP_MFLO, ALUOP_MTLO, ALUOP_MFLO};
    word_t  model_hi = '0;
    word_t  model_lo = '0;
    int     passed   = 0;
    int     failed   = 0;
    bit     built    = 1'b0;

    exe_top dut (.*);

    bind exe_top exe_top_sva u_sva (
        .div_done   (div_done),
        .reset_i    (reset_i),
        .issue_i    (issue_i),
        .valid_i    (result_valid_o),
        .addr_i     (result_addr_o),
        .ovf_i      (overflow_o),
        .hi_i       (hi_o),
        .buf_valid_i(mem_res.valid),
        .buf_hi_we_i(mem_res.hi_we)
    );

    initial begin
        div_done = 1'b0;
        forever #(PERIOD_NS / 2) div_done = ~div_done;
    end

    function automatic word_t link_of(input int idx);
        return LINK_BASE + word_t'(idx * 8);
    endfunction

    function automatic logic writes_gpr(input aluop_e op);
        return !(op inside {ALUOP_NOP, ALUOP_MTHI, ALUOP_MTLO, ALUOP_MULT, ALUOP_MULTU});
    endfunction

    // MIPS32 rules for one instruction, tracks the architectural HI/LO
    task automatic predict(input aluop_e op, input word_t rs, input word_t rt,
                           input word_t instr, input word_t link, input gpr_addr_t dest,
                           output word_t data, output gpr_addr_t addr, output logic ovf);
        logic [32:0] wide;
        logic [63:0] prod;
        word_t       simm;
        word_t       zimm;
        word_t       b;
        simm = {{16{instr[15]}}, instr[15:0]};
        zimm = {16'h0, instr[15:0]};
        b    = (op == ALUOP_ADDI) ? simm : rt;
        wide = (op == ALUOP_SUB) ? {rs[31], rs} - {b[31], b} : {rs[31], rs} + {b[31], b};
        data = '0;
        addr = dest;
        ovf  = 1'b0;
        case (op)
            ALUOP_ADD, ALUOP_ADDI, ALUOP_SUB: begin
                data = wide[31:0];
                ovf  = wide[32] ^ wide[31];
            end
            ALUOP_ADDU:  data = rs + rt;
            ALUOP_ADDIU: data = rs + simm;
            ALUOP_SUBU:  data = rs - rt;
            ALUOP_SLT:   data = {31'h0, $signed(rs) < $signed(rt)};
            ALUOP_SLTI:  data = {31'h0, $signed(rs) < $signed(simm)};
            ALUOP_SLTU:  data = {31'h0, rs < rt};
            ALUOP_SLTIU: data = {31'h0, rs < simm};
            ALUOP_AND:   data = rs & rt;
            ALUOP_ANDI:  data = rs & zimm;
            ALUOP_OR:    data = rs | rt;
            ALUOP_ORI:   data = rs | zimm;
            ALUOP_XOR:   data = rs ^ rt;
            ALUOP_XORI:  data = rs ^ zimm;
            ALUOP_NOR:   data = ~(rs | rt);
            ALUOP_LUI:   data = {instr[15:0], 16'h0};
            ALUOP_SLL:   data = rt << instr[10:6];
            ALUOP_SLLV:  data = rt << rs[4:0];
            ALUOP_SRL:   data = rt >> instr[10:6];
            ALUOP_SRLV:  data = rt >> rs[4:0];
            ALUOP_SRA:   data = word_t'($signed(rt) >>> instr[10:6]);
            ALUOP_SRAV:  data = word_t'($signed(rt) >>> rs[4:0]);
            ALUOP_JAL, ALUOP_BGEZAL, ALUOP_BLTZAL: begin
                data = link;
                addr = 5'd31;
            end
            ALUOP_JALR: begin
                data = link;
                addr = instr[15:11];
            end
            ALUOP_MFHI: data = model_hi;
            ALUOP_MFLO: data = model_lo;
            ALUOP_MTHI: model_hi = rs;
            ALUOP_MTLO: model_lo = rs;
            ALUOP_MULT, ALUOP_MULTU: begin
                if (op == ALUOP_MULT) begin
                    prod = $signed({{32{rs[31]}}, rs}) * $signed({{32{rt[31]}}, rt});
                end else begin
                    prod = {32'h0, rs} * {32'h0, rt};
                end
                model_hi = prod[63:32];
                model_lo = prod[31:0];
            end
            ALUOP_LB, ALUOP_LBU, ALUOP_LH, ALUOP_LHU, ALUOP_LW,
            ALUOP_SB, ALUOP_SH, ALUOP_SW: data = rs + simm;
            default: data = '0;
        endcase
        if (ovf) begin
            addr = 5'd0;
        end
    endtask

    // directed rows keep their own data, address and overflow
    task automatic add_row(input string name, input aluop_e op, input word_t rs,
                           input word_t rt, input word_t instr, input gpr_addr_t dest,
                           input bit directed, input word_t data, input gpr_addr_t addr,
                           input logic ovf);
        word_t     m_data;
        gpr_addr_t m_addr;
        logic      m_ovf;
        predict(op, rs, rt, instr, link_of(rows.size()), dest, m_data, m_addr, m_ovf);
        if (directed) begin
            rows.push_back('{name, op, rs, rt, instr, dest, data, addr, ovf,
                             model_hi, model_lo, 1'b0});
        end else begin
            rows.push_back('{name, op, rs, rt, instr, dest, m_data, m_addr, m_ovf,
                             model_hi, model_lo, 1'b0});
        end
    endtask

    task automatic add_rand(input aluop_e op);
        word_t rs;
        word_t rt;
        word_t instr;
        rs    = $urandom;
        rt    = $urandom;
        instr = $urandom;
        add_row($sformatf("%s_rand", op.name()), op, rs, rt, instr, gpr_addr_t'($urandom),
                1'b0, '0, '0, 1'b0);
    endtask

    task automatic build_table();
        add_row("add", ALUOP_ADD, 32'd5, 32'd7, '0, 5'd3, 1, 32'd12, 5'd3, 0);
        add_row("sltu", ALUOP_SLTU, 32'hffff_ffff, 32'd1, '0, 5'd5, 1, 32'd0, 5'd5, 0);
        add_row("nor", ALUOP_NOR, 32'hf0f0_0000, 32'h0f00_0000, '0, 5'd6, 1,
                32'h000f_ffff, 5'd6, 0);
        add_row("ori", ALUOP_ORI, 32'h1234_0000, '0, 32'h0000_8001, 5'd7, 1,
                32'h1234_8001, 5'd7, 0);
        add_row("lui", ALUOP_LUI, '0, '0, 32'h0000_abcd, 5'd8, 1, 32'habcd_0000, 5'd8, 0);
        add_row("sra", ALUOP_SRA, '0, 32'h8000_0000, 32'h0000_0100, 5'd9, 1,
                32'hf800_0000, 5'd9, 0);
        add_row("srlv", ALUOP_SRLV, 32'd31, 32'h8000_0000, '0, 5'd10, 1, 32'd1, 5'd10, 0);
        add_row("lw", ALUOP_LW, 32'h1000_0000, '0, 32'h0000_fffc, 5'd11, 1,
                32'h0fff_fffc, 5'd11, 0);
        // signs that force overflow, then the unsigned forms
        add_row("add_ovf", ALUOP_ADD, 32'h7fff_ffff, 32'd1, '0, 5'd12, 1,
                32'h8000_0000, 5'd0, 1);
        add_row("addu_same", ALUOP_ADDU, 32'h7fff_ffff, 32'd1, '0, 5'd12, 1,
                32'h8000_0000, 5'd12, 0);
        add_row("addi_ovf", ALUOP_ADDI, 32'h8000_0000, '0, 32'h0000_ffff, 5'd13, 1,
                32'h7fff_ffff, 5'd0, 1);
        add_row("addiu_same", ALUOP_ADDIU, 32'h8000_0000, '0, 32'h0000_ffff, 5'd13, 1,
                32'h7fff_ffff, 5'd13, 0);
        add_row("sub_ovf", ALUOP_SUB, 32'h8000_0000, 32'd1, '0, 5'd14, 1,
                32'h7fff_ffff, 5'd0, 1);
        add_row("subu_same", ALUOP_SUBU, 32'h8000_0000, 32'd1, '0, 5'd14, 1,
                32'h7fff_ffff, 5'd14, 0);
        add_row("jal", ALUOP_JAL, '0, '0, '0, 5'd2, 1, link_of(rows.size()), 5'd31, 0);
        add_row("bgezal", ALUOP_BGEZAL, '0, '0, '0, 5'd2, 1, link_of(rows.size()), 5'd31, 0);
        // back to back MTHI/MFHI, then two cycles apart
        add_row("mthi", ALUOP_MTHI, 32'h1234_5678, '0, '0, 5'd0, 1, '0, 5'd0, 0);
        add_row("mfhi_fwd", ALUOP_MFHI, '0, '0, '0, 5'd15, 1, 32'h1234_5678, 5'd15, 0);
        add_row("mtlo", ALUOP_MTLO, 32'h9abc_def0, '0, '0, 5'd0, 1, '0, 5'd0, 0);
        add_row("mthi_2", ALUOP_MTHI, 32'hcafe_f00d, '0, '0, 5'd0, 1, '0, 5'd0, 0);
        add_row("nop", ALUOP_NOP, '0, '0, '0, 5'd0, 1, '0, 5'd0, 0);
        add_row("mfhi_commit", ALUOP_MFHI, '0, '0, '0, 5'd16, 1, 32'hcafe_f00d, 5'd16, 0);
        add_row("mflo", ALUOP_MFLO, '0, '0, '0, 5'd17, 1, 32'h9abc_def0, 5'd17, 0);
        foreach (rand_ops[k]) begin
            add_rand(rand_ops[k]);
        end
    endtask

    function automatic bit mismatch(input string test, input string what,
                                    input word_t exp, input word_t act);
        mismatch = 1'b0;
        assert (act === exp) else begin
            $display("ERROR %s %s expected %h actual %h", test, what, exp, act);
            mismatch = 1'b1;
        end
    endfunction

    function automatic bit idle_wrong(input string test);
        bit bad;
        bad = mismatch(test, "valid", 32'd0, 32'(result_valid_o));
        bad |= mismatch(test, "we", 32'd0, 32'(result_we_o));
        bad |= mismatch(test, "overflow", 32'd0, 32'(overflow_o));
        bad |= mismatch(test, "hi", 32'd0, hi_o);
        bad |= mismatch(test, "lo", 32'd0, lo_o);
        return bad;
    endfunction

    task automatic report(input string test, input bit bad);
        if (bad) begin
            failed++;
        end else begin
            passed++;
        end
        $display("%-16s %s", test, bad ? "FAIL" : "ok");
    endtask

    task automatic drive(input int i);
        issue_i     = 1'b1;
        aluop_i     = rows[i].op;
        rs_data_i   = rows[i].rs;
        rt_data_i   = rows[i].rt;
        instr_i     = rows[i].instr;
        link_addr_i = link_of(i);
        dest_addr_i = rows[i].dest;
        reg_write_i = writes_gpr(rows[i].op);
    endtask

    task automatic check_result(input int i);
        bit bad;
        bad = mismatch(rows[i].name, "valid", 32'd1, 32'(result_valid_o));
        bad |= mismatch(rows[i].name, "we", 32'(writes_gpr(rows[i].op)), 32'(result_we_o));
        if (writes_gpr(rows[i].op)) begin
            bad |= mismatch(rows[i].name, "data", rows[i].exp_data, result_data_o);
        end
        bad |= mismatch(rows[i].name, "addr", 32'(rows[i].exp_addr), 32'(result_addr_o));
        bad |= mismatch(rows[i].name, "overflow", 32'(rows[i].exp_ovf), 32'(overflow_o));
        rows[i].bad = bad;
    endtask

    task automatic check_hilo(input int i);
        bit bad;
        bad = rows[i].bad;
        bad |= mismatch(rows[i].name, "hi", rows[i].exp_hi, hi_o);
        bad |= mismatch(rows[i].name, "lo", rows[i].exp_lo, lo_o);
        report(rows[i].name, bad);
    endtask

    initial begin
        wait (built);
        #((RESET_CYCLES + rows.size() + 20) * PERIOD_NS);
        $display("watchdog expired before all tests completed");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        bit bad;
        reset_i     = 1'b1;
        // a write attempt during reset must not reach HI
        issue_i     = 1'b1;
        aluop_i     = ALUOP_MTHI;
        rs_data_i   = '1;
        rt_data_i   = '1;
        instr_i     = '0;
        link_addr_i = '0;
        dest_addr_i = 5'd1;
        reg_write_i = 1'b1;
        void'($urandom(32'h6dec_4d7c));
        build_table();
        built = 1'b1;
        bad = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge div_done);
            bad |= idle_wrong("reset");
        end
        report("reset", bad);
        reset_i     = 1'b0;
        issue_i     = 1'b0;
        reg_write_i = 1'b0;
        @(negedge div_done);
        report("after_reset", idle_wrong("after_reset"));
        // results one cycle after issue, HI/LO one cycle later
        for (int i = 0; i < rows.size() + 2; i++) begin
            if (i >= 1 && i - 1 < rows.size()) begin
                check_result(i - 1);
            end
            if (i >= 2) begin
                check_hilo(i - 2);
            end
            if (i < rows.size()) begin
                drive(i);
            end else begin
                issue_i = 1'b0;
            end
            @(negedge div_done);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
                 passed + failed, passed, failed, dut.u_sva.fail_count);
        if (failed == 0 && dut.u_sva.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- exe_top.f
hdl/mips_isa_pkg.sv
hdl/exe_types_pkg.sv
hdl/exe_result_if.sv
hdl/exe_alu.sv
hdl/exe_stage_reg.sv
hdl/hilo_regs.sv
hdl/exe_top.sv
test/exe_top_sva.sv
test/exe_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= exe_top_tb
FILELIST  ?= exe_top.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
